//--- verilog/cpu_types_pkg.sv
package cpu_types_pkg;

    // Core-wide sizes
    localparam int addr_width     = 32;
    localparam int arch_reg_count = 32;
    localparam int phys_reg_count = 64;
    localparam int rob_size       = 32;

    // Index widths follow from the sizes above
    localparam int arch_idx_width = $clog2(arch_reg_count);
    localparam int phys_idx_width = $clog2(phys_reg_count);
    localparam int rob_idx_width  = $clog2(rob_size);

    // Program counter value
    typedef logic [addr_width-1:0] addr_t;

    // Architectural register index, register 0 means no destination
    typedef logic [arch_idx_width-1:0] arch_idx_t;

    // Physical register index
    typedef logic [phys_idx_width-1:0] phys_idx_t;

    // Reorder buffer slot
    typedef logic [rob_idx_width-1:0] rob_idx_t;

    // One bit per physical register, set when the register is free
    typedef logic [phys_reg_count-1:0] free_vec_t;

    // Whole map table, indexed by architectural register
    typedef phys_idx_t [arch_reg_count-1:0] map_vec_t;

endpackage

//--- verilog/branch_pkg.sv
package branch_pkg;

    // Number of unresolved branches that can be in flight
    localparam int b_mask_width = 4;

    // One bit per in-flight branch
    typedef logic [b_mask_width-1:0] b_mask_t;

    // Control transfer class of a dispatched instruction
    typedef enum logic [1:0] {
        kind_none,
        kind_cond,
        kind_jump
    } branch_kind_e;

    // Checkpoint taken when a branch or jump is dispatched
    typedef struct packed {
        // Slot holds a live checkpoint
        logic                     valid;
        branch_kind_e             kind;
        // Older branches this checkpoint depends on
        b_mask_t                  b_mask;
        cpu_types_pkg::addr_t     branch_pc;
        cpu_types_pkg::addr_t     predicted_pc;
        cpu_types_pkg::rob_idx_t  rob_tail;
        // Rename state right after the branch's own rename
        cpu_types_pkg::free_vec_t free_list;
        cpu_types_pkg::map_vec_t  map_table;
    } bs_entry_t;

endpackage

//--- verilog/branch_ifs.sv
`timescale 1ns/1ps

// Branch resolution from the complete stage
interface resolve_if;

    logic                 valid;
    // One-hot mask bit of the resolving branch
    branch_pkg::b_mask_t  tag;
    logic                 taken;
    cpu_types_pkg::addr_t target;

    modport src (
        output valid,
        output tag,
        output taken,
        output target
    );

    modport dst (
        input valid,
        input tag,
        input taken,
        input target
    );

endinterface

// Rename state recovery after a mispredict
interface restore_if;

    logic                     valid;
    // Checkpoints that depend on the mispredicted branch
    branch_pkg::b_mask_t      squash_mask;
    cpu_types_pkg::map_vec_t  map_table;
    cpu_types_pkg::free_vec_t free_list;

    modport src (
        output valid,
        output squash_mask,
        output map_table,
        output free_list
    );

    modport dst (
        input valid,
        input squash_mask,
        input map_table,
        input free_list
    );

endinterface

//--- verilog/branch_mask_alloc.sv
`timescale 1ns/1ps

module branch_mask_alloc (
    input  logic                clock,
    input  logic                reset,
    resolve_if.dst              res,
    input  logic                mispredict,
    input  branch_pkg::b_mask_t squash_mask,
    input  logic                alloc,
    output branch_pkg::b_mask_t free_tag,
    output branch_pkg::b_mask_t busy,
    output logic                full
);

    branch_pkg::b_mask_t clear_mask;
    branch_pkg::b_mask_t busy_avail;

    // Bits released by this cycle's resolve
    always_comb begin
        clear_mask = '0;
        if (res.valid) begin
            clear_mask = res.tag;
            // Younger branches on the wrong path give their bits back too
            if (mispredict) begin
                clear_mask = clear_mask | squash_mask;
            end
        end
    end

    // Resolve goes first, so a same-cycle dispatch can reuse a released bit
    assign busy_avail = busy & ~clear_mask;

    // Lowest free bit, one-hot
    always_comb begin
        free_tag = '0;
        for (int i = branch_pkg::b_mask_width - 1; i >= 0; i--) begin
            if (!busy_avail[i]) begin
                free_tag    = '0;
                free_tag[i] = 1'b1;
            end
        end
    end

    assign full = &busy_avail;

    always_ff @(posedge clock) begin
        if (reset) begin
            busy <= '0;
        end else if (alloc && !full) begin
            busy <= busy_avail | free_tag;
        end else begin
            busy <= busy_avail;
        end
    end

endmodule

//--- verilog/rename_state.sv
`timescale 1ns/1ps

module rename_state (
    input  logic                     clock,
    input  logic                     reset,
    input  cpu_types_pkg::arch_idx_t dest,
    input  logic                     alloc,
    output cpu_types_pkg::phys_idx_t new_preg,
    output logic                     no_free,
    output cpu_types_pkg::map_vec_t  map_table,
    output cpu_types_pkg::free_vec_t free_list,
    input  logic                     retire_valid,
    input  cpu_types_pkg::phys_idx_t retire_preg,
    restore_if.dst                   rst
);

    // Registered rename state
    cpu_types_pkg::map_vec_t  map_q;
    cpu_types_pkg::free_vec_t free_q;

    // State after restore and retire, before this cycle's allocation
    cpu_types_pkg::map_vec_t  map_base;
    cpu_types_pkg::free_vec_t free_avail;

    logic do_alloc;

    always_comb begin
        if (rst.valid) begin
            map_base   = rst.map_table;
            free_avail = rst.free_list;
        end else begin
            map_base   = map_q;
            free_avail = free_q;
        end
        // A retire in the restore cycle is not lost
        if (retire_valid) begin
            free_avail[retire_preg] = 1'b1;
        end
    end

    // Priority pick, the lowest numbered free register wins
    always_comb begin
        new_preg = '0;
        for (int i = cpu_types_pkg::phys_reg_count - 1; i >= 0; i--) begin
            if (free_avail[i]) begin
                new_preg = cpu_types_pkg::phys_idx_t'(i);
            end
        end
    end

    assign no_free = ~|free_avail;

    // Architectural register 0 never gets a new mapping
    assign do_alloc = alloc && (dest != '0) && !no_free;

    // Next state, also the checkpoint source for a branch dispatched now
    always_comb begin
        map_table = map_base;
        free_list = free_avail;
        if (do_alloc) begin
            map_table[dest]     = new_preg;
            free_list[new_preg] = 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            // Identity map, the first arch_reg_count registers are in use
            for (int i = 0; i < cpu_types_pkg::arch_reg_count; i++) begin
                map_q[i] <= cpu_types_pkg::phys_idx_t'(i);
            end
            for (int i = 0; i < cpu_types_pkg::phys_reg_count; i++) begin
                free_q[i] <= (i >= cpu_types_pkg::arch_reg_count);
            end
        end else begin
            map_q  <= map_table;
            free_q <= free_list;
        end
    end

endmodule

//--- verilog/branch_stack.sv
`timescale 1ns/1ps

module branch_stack (
    input  logic                     clock,
    input  logic                     reset,
    resolve_if.dst                   res,
    input  logic                     push,
    input  branch_pkg::b_mask_t      push_tag,
    input  branch_pkg::branch_kind_e push_kind,
    input  branch_pkg::b_mask_t      push_deps,
    input  cpu_types_pkg::addr_t     push_pc,
    input  cpu_types_pkg::addr_t     push_predicted_pc,
    input  cpu_types_pkg::rob_idx_t  push_rob_tail,
    input  cpu_types_pkg::map_vec_t  map_in,
    input  cpu_types_pkg::free_vec_t free_in,
    input  logic                     retire_valid,
    input  cpu_types_pkg::phys_idx_t retire_preg,
    restore_if.src                   rst,
    output cpu_types_pkg::addr_t     restore_pc,
    output cpu_types_pkg::rob_idx_t  restore_rob_tail,
    output logic                     mispredict
);

    // One checkpoint per mask bit
    branch_pkg::bs_entry_t entries   [branch_pkg::b_mask_width];
    branch_pkg::bs_entry_t entries_n [branch_pkg::b_mask_width];

    // Checkpoint of the resolving branch
    branch_pkg::bs_entry_t    sel;
    cpu_types_pkg::addr_t     actual_pc;
    branch_pkg::b_mask_t      dependents;
    branch_pkg::b_mask_t      strip_mask;
    cpu_types_pkg::free_vec_t retire_vec;

    always_comb begin
        sel = '0;
        for (int i = 0; i < branch_pkg::b_mask_width; i++) begin
            if (res.tag[i]) begin
                sel = entries[i];
            end
        end
    end

    // Jumps always go to the target
    always_comb begin
        if (res.taken || sel.kind == branch_pkg::kind_jump) begin
            actual_pc = res.target;
        end else begin
            actual_pc = sel.branch_pc + 32'd4;
        end
    end

    assign mispredict = res.valid && sel.valid && (actual_pc != sel.predicted_pc);

    // Live checkpoints younger than the resolving branch
    always_comb begin
        for (int i = 0; i < branch_pkg::b_mask_width; i++) begin
            dependents[i] = entries[i].valid && |(entries[i].b_mask & res.tag);
        end
    end

    assign rst.valid       = mispredict;
    assign rst.squash_mask = mispredict ? dependents : '0;
    assign rst.map_table   = sel.map_table;
    assign rst.free_list   = sel.free_list;

    assign restore_pc       = mispredict ? actual_pc : '0;
    assign restore_rob_tail = mispredict ? sel.rob_tail : '0;

    assign strip_mask = res.valid ? res.tag : '0;

    always_comb begin
        retire_vec = '0;
        if (retire_valid) begin
            retire_vec[retire_preg] = 1'b1;
        end
    end

    always_comb begin
        for (int i = 0; i < branch_pkg::b_mask_width; i++) begin
            entries_n[i] = entries[i];
            if (strip_mask[i] || (mispredict && dependents[i])) begin
                entries_n[i].valid = 1'b0;
            end else if (entries[i].valid) begin
                // Survivor no longer waits on the resolved branch
                entries_n[i].b_mask    = entries[i].b_mask & ~strip_mask;
                entries_n[i].free_list = entries[i].free_list | retire_vec;
            end
            // New checkpoint may reuse a slot released this cycle
            if (push && push_tag[i]) begin
                entries_n[i].valid        = 1'b1;
                entries_n[i].kind         = push_kind;
                entries_n[i].b_mask       = push_deps;
                entries_n[i].branch_pc    = push_pc;
                entries_n[i].predicted_pc = push_predicted_pc;
                entries_n[i].rob_tail     = push_rob_tail;
                entries_n[i].free_list    = free_in;
                entries_n[i].map_table    = map_in;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < branch_pkg::b_mask_width; i++) begin
                entries[i].valid <= 1'b0;
            end
        end else begin
            entries <= entries_n;
        end
    end

endmodule

//--- verilog/branch_recovery_unit.sv
`timescale 1ns/1ps

module branch_recovery_unit (
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     disp_req,
    input  branch_pkg::branch_kind_e disp_kind,
    input  cpu_types_pkg::arch_idx_t disp_dest,
    input  cpu_types_pkg::addr_t     disp_pc,
    input  cpu_types_pkg::addr_t     disp_predicted_pc,
    input  cpu_types_pkg::rob_idx_t  disp_rob_tail,
    output logic                     disp_ack,
    output cpu_types_pkg::phys_idx_t disp_preg,
    output branch_pkg::b_mask_t      disp_tag,
    input  logic                     resolve_valid,
    input  branch_pkg::b_mask_t      resolve_tag,
    input  logic                     resolve_taken,
    input  cpu_types_pkg::addr_t     resolve_target,
    input  logic                     retire_valid,
    input  cpu_types_pkg::phys_idx_t retire_preg,
    output logic                     restore_valid,
    output cpu_types_pkg::addr_t     restore_pc,
    output cpu_types_pkg::rob_idx_t  restore_rob_tail,
    output logic                     resolve_mispredict
);

    typedef enum logic [1:0] {
        disp_idle,
        disp_acked,
        disp_wait_low
    } disp_state_e;

    disp_state_e state;

    branch_pkg::b_mask_t      free_tag;
    branch_pkg::b_mask_t      busy;
    branch_pkg::b_mask_t      deps;
    logic                     full;
    cpu_types_pkg::phys_idx_t new_preg;
    logic                     no_free;
    cpu_types_pkg::map_vec_t  map_next;
    cpu_types_pkg::free_vec_t free_next;
    logic                     mispredict;
    logic                     is_branch;
    logic                     need_preg;
    logic                     can_serve;
    logic                     fire;

    resolve_if res_bus ();
    restore_if rst_bus ();

    assign res_bus.valid  = resolve_valid;
    assign res_bus.tag    = resolve_tag;
    assign res_bus.taken  = resolve_taken;
    assign res_bus.target = resolve_target;

    assign is_branch = (disp_kind != branch_pkg::kind_none);
    assign need_preg = (disp_dest != '0);

    // Back-pressure until the needed resources are free
    assign can_serve = (!is_branch || !full) && (!need_preg || !no_free);
    assign fire      = (state == disp_idle) && disp_req && can_serve;

    // Older branches still pending after this cycle's resolve
    assign deps = busy & ~(resolve_valid ? resolve_tag : '0)
                       & ~(mispredict ? rst_bus.squash_mask : '0);

    // Ack rises on fire and stays up until the request drops
    always_ff @(posedge clock) begin
        if (reset) begin
            state <= disp_idle;
        end else begin
            case (state)
                disp_idle:     state <= fire ? disp_acked : disp_idle;
                disp_acked:    state <= disp_req ? disp_wait_low : disp_idle;
                disp_wait_low: state <= disp_req ? disp_wait_low : disp_idle;
                default:       state <= disp_idle;
            endcase
        end
    end

    assign disp_ack = (state != disp_idle);

    // Results held for the whole ack phase
    always_ff @(posedge clock) begin
        if (fire) begin
            disp_preg <= need_preg ? new_preg : '0;
            disp_tag  <= is_branch ? free_tag : '0;
        end
    end

    branch_mask_alloc u_mask_alloc (
        .clock       (clock),
        .reset       (reset),
        .res         (res_bus),
        .mispredict  (mispredict),
        .squash_mask (rst_bus.squash_mask),
        .alloc       (fire && is_branch),
        .free_tag    (free_tag),
        .busy        (busy),
        .full        (full)
    );

    rename_state u_rename (
        .clock        (clock),
        .reset        (reset),
        .dest         (disp_dest),
        .alloc        (fire),
        .new_preg     (new_preg),
        .no_free      (no_free),
        .map_table    (map_next),
        .free_list    (free_next),
        .retire_valid (retire_valid),
        .retire_preg  (retire_preg),
        .rst          (rst_bus)
    );

    branch_stack u_stack (
        .clock             (clock),
        .reset             (reset),
        .res               (res_bus),
        .push              (fire && is_branch),
        .push_tag          (free_tag),
        .push_kind         (disp_kind),
        .push_deps         (deps),
        .push_pc           (disp_pc),
        .push_predicted_pc (disp_predicted_pc),
        .push_rob_tail     (disp_rob_tail),
        .map_in            (map_next),
        .free_in           (free_next),
        .retire_valid      (retire_valid),
        .retire_preg       (retire_preg),
        .rst               (rst_bus),
        .restore_pc        (restore_pc),
        .restore_rob_tail  (restore_rob_tail),
        .mispredict        (mispredict)
    );

    assign restore_valid      = rst_bus.valid;
    assign resolve_mispredict = mispredict;

endmodule

//--- dv/branch_recovery_tb.sv
`timescale 1ns/1ps

module branch_recovery_tb;

    typedef enum logic [1:0] {
        op_disp,
        op_resolve,
        op_retire
    } op_e;

    // One row of stimulus with unused fields left at zero
    typedef struct packed {
        op_e                      op;
        branch_pkg::branch_kind_e kind;
        cpu_types_pkg::arch_idx_t dest;
        cpu_types_pkg::addr_t     pc;
        cpu_types_pkg::addr_t     pred;
        cpu_types_pkg::rob_idx_t  rob;
        logic                     held;
        branch_pkg::b_mask_t      tag;
        logic                     taken;
        cpu_types_pkg::addr_t     target;
        logic                     exp_mis;
    } row_t;

    logic                     clock;
    logic                     reset;
    logic                     disp_req;
    branch_pkg::branch_kind_e disp_kind;
    cpu_types_pkg::arch_idx_t disp_dest;
    cpu_types_pkg::addr_t     disp_pc;
    cpu_types_pkg::addr_t     disp_predicted_pc;
    cpu_types_pkg::rob_idx_t  disp_rob_tail;
    logic                     disp_ack;
    cpu_types_pkg::phys_idx_t disp_preg;
    branch_pkg::b_mask_t      disp_tag;
    logic                     resolve_valid;
    branch_pkg::b_mask_t      resolve_tag;
    logic                     resolve_taken;
    cpu_types_pkg::addr_t     resolve_target;
    logic                     retire_valid;
    cpu_types_pkg::phys_idx_t retire_preg;
    logic                     restore_valid;
    cpu_types_pkg::addr_t     restore_pc;
    cpu_types_pkg::rob_idx_t  restore_rob_tail;
    logic                     resolve_mispredict;

    row_t ops[$];
    int   cycles = 0;
    int   cycle_limit = 0;

    // Reference model of the rename and branch state
    cpu_types_pkg::map_vec_t  ref_map;
    cpu_types_pkg::free_vec_t ref_free;
    branch_pkg::b_mask_t      ref_busy;
    branch_pkg::bs_entry_t    ref_ckpt [branch_pkg::b_mask_width];
    row_t                     pending;
    logic                     have_pending;

    branch_recovery_unit uut (
        .clock              (clock),
        .reset              (reset),
        .disp_req           (disp_req),
        .disp_kind          (disp_kind),
        .disp_dest          (disp_dest),
        .disp_pc            (disp_pc),
        .disp_predicted_pc  (disp_predicted_pc),
        .disp_rob_tail      (disp_rob_tail),
        .disp_ack           (disp_ack),
        .disp_preg          (disp_preg),
        .disp_tag           (disp_tag),
        .resolve_valid      (resolve_valid),
        .resolve_tag        (resolve_tag),
        .resolve_taken      (resolve_taken),
        .resolve_target     (resolve_target),
        .retire_valid       (retire_valid),
        .retire_preg        (retire_preg),
        .restore_valid      (restore_valid),
        .restore_pc         (restore_pc),
        .restore_rob_tail   (restore_rob_tail),
        .resolve_mispredict (resolve_mispredict)
    );

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    task automatic fail_run();
        $display(">>> FAIL");
        $fatal(1, "Run stopped at the first error");
    endtask

    always @(posedge clock) begin
        cycles++;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("Timeout: the DUT stopped responding after %0d cycles", cycles);
            fail_run();
        end
    end

    task automatic check_preg(input cpu_types_pkg::phys_idx_t act,
                              input cpu_types_pkg::phys_idx_t exp, input string what);
        if (act !== exp) begin
            $display("Mismatch at %0t: %s is %0d, expected %0d", $time, what, act, exp);
            fail_run();
        end
    endtask

    task automatic check_tag(input branch_pkg::b_mask_t act,
                             input branch_pkg::b_mask_t exp, input string what);
        if (act !== exp) begin
            $display("Mismatch at %0t: %s is %b, expected %b", $time, what, act, exp);
            fail_run();
        end
    endtask

    task automatic check_pc(input cpu_types_pkg::addr_t act,
                            input cpu_types_pkg::addr_t exp, input string what);
        if (act !== exp) begin
            $display("Mismatch at %0t: %s is %h, expected %h", $time, what, act, exp);
            fail_run();
        end
    endtask

    task automatic check_rob(input cpu_types_pkg::rob_idx_t act,
                             input cpu_types_pkg::rob_idx_t exp, input string what);
        if (act !== exp) begin
            $display("Mismatch at %0t: %s is %0d, expected %0d", $time, what, act, exp);
            fail_run();
        end
    endtask

    task automatic check_flag(input logic act, input logic exp, input string what);
        if (act !== exp) begin
            $display("Mismatch at %0t: %s is %b, expected %b", $time, what, act, exp);
            fail_run();
        end
    endtask

    function automatic void add_disp(input branch_pkg::branch_kind_e kind, input int dest,
                                     input int pc, input int pred, input int rob,
                                     input logic held);
        row_t r;
        r = '0;
        r.op   = op_disp;
        r.kind = kind;
        r.dest = cpu_types_pkg::arch_idx_t'(dest);
        r.pc   = pc;
        r.pred = pred;
        r.rob  = cpu_types_pkg::rob_idx_t'(rob);
        r.held = held;
        ops.push_back(r);
    endfunction

    function automatic void add_resolve(input int tag, input logic taken, input int target,
                                        input logic exp_mis);
        row_t r;
        r = '0;
        r.op      = op_resolve;
        r.tag     = branch_pkg::b_mask_t'(tag);
        r.taken   = taken;
        r.target  = target;
        r.exp_mis = exp_mis;
        ops.push_back(r);
    endfunction

    function automatic void add_retire();
        row_t r;
        r = '0;
        r.op = op_retire;
        ops.push_back(r);
    endfunction

    function automatic void build_ops();
        // Plain renames take 32, 33, 34
        add_disp(branch_pkg::kind_none, 1, 'h0f0, 'h0f4, 1, 1'b0);
        add_disp(branch_pkg::kind_none, 2, 'h0f4, 'h0f8, 2, 1'b0);
        add_disp(branch_pkg::kind_none, 3, 'h0f8, 'h0fc, 2, 1'b0);
        // Four branches fill every mask bit and the fifth must wait
        add_disp(branch_pkg::kind_cond, 0, 'h100, 'h104, 3, 1'b0);
        add_disp(branch_pkg::kind_cond, 4, 'h200, 'h300, 5, 1'b0);
        add_disp(branch_pkg::kind_jump, 5, 'h400, 'h800, 7, 1'b0);
        add_disp(branch_pkg::kind_cond, 0, 'h500, 'h504, 9, 1'b0);
        add_disp(branch_pkg::kind_cond, 6, 'h600, 'h604, 11, 1'b1);
        add_resolve('b0001, 1'b0, 'h0, 1'b0);
        add_disp(branch_pkg::kind_none, 7, 'h604, 'h608, 11, 1'b0);
        // Retired after the checkpoint of tag 0010 and kept free by the restore
        add_retire();
        add_resolve('b0010, 1'b1, 'h280, 1'b1);
        add_disp(branch_pkg::kind_cond, 8, 'h610, 'h614, 12, 1'b0);
        add_disp(branch_pkg::kind_cond, 0, 'h620, 'h700, 13, 1'b0);
        // A jump that matches its prediction and then one that does not
        add_disp(branch_pkg::kind_jump, 9, 'h700, 'h900, 14, 1'b0);
        add_resolve('b0100, 1'b1, 'h900, 1'b0);
        add_disp(branch_pkg::kind_jump, 0, 'h740, 'h744, 15, 1'b0);
        add_resolve('b0100, 1'b0, 'ha00, 1'b1);
        add_resolve('b0010, 1'b1, 'h700, 1'b0);
        add_resolve('b0001, 1'b0, 'h0, 1'b0);
        add_retire();
        add_disp(branch_pkg::kind_none, 10, 'ha00, 'ha04, 16, 1'b0);
        add_disp(branch_pkg::kind_none, 11, 'ha04, 'ha08, 17, 1'b0);
    endfunction

    function automatic int lowest_free_slot();
        int slot;
        slot = 0;
        for (int i = branch_pkg::b_mask_width - 1; i >= 0; i--) begin
            if (!ref_busy[i]) begin
                slot = i;
            end
        end
        return slot;
    endfunction

    function automatic int slot_of(input branch_pkg::b_mask_t tag);
        int slot;
        slot = 0;
        for (int i = 0; i < branch_pkg::b_mask_width; i++) begin
            if (tag[i]) begin
                slot = i;
            end
        end
        return slot;
    endfunction

    function automatic cpu_types_pkg::phys_idx_t lowest_free_preg();
        cpu_types_pkg::phys_idx_t preg;
        preg = '0;
        for (int i = cpu_types_pkg::phys_reg_count - 1; i >= 0; i--) begin
            if (ref_free[i]) begin
                preg = cpu_types_pkg::phys_idx_t'(i);
            end
        end
        return preg;
    endfunction

    function automatic void model_reset();
        for (int i = 0; i < cpu_types_pkg::arch_reg_count; i++) begin
            ref_map[i] = cpu_types_pkg::phys_idx_t'(i);
        end
        for (int i = 0; i < cpu_types_pkg::phys_reg_count; i++) begin
            ref_free[i] = (i >= cpu_types_pkg::arch_reg_count);
        end
        ref_busy = '0;
        for (int i = 0; i < branch_pkg::b_mask_width; i++) begin
            ref_ckpt[i] = '0;
        end
    endfunction

    // Rename before the checkpoint so the branch keeps its own mapping
    task automatic model_dispatch(input row_t r, output cpu_types_pkg::phys_idx_t exp_preg,
                                  output branch_pkg::b_mask_t exp_tag);
        int slot;
        exp_preg = '0;
        exp_tag  = '0;
        if (r.dest != '0) begin
            exp_preg = lowest_free_preg();
            ref_free[exp_preg] = 1'b0;
            ref_map[r.dest]    = exp_preg;
        end
        if (r.kind != branch_pkg::kind_none) begin
            slot = lowest_free_slot();
            exp_tag[slot] = 1'b1;
            ref_ckpt[slot].valid        = 1'b1;
            ref_ckpt[slot].kind         = r.kind;
            ref_ckpt[slot].b_mask       = ref_busy;
            ref_ckpt[slot].branch_pc    = r.pc;
            ref_ckpt[slot].predicted_pc = r.pred;
            ref_ckpt[slot].rob_tail     = r.rob;
            ref_ckpt[slot].free_list    = ref_free;
            ref_ckpt[slot].map_table    = ref_map;
            ref_busy[slot] = 1'b1;
        end
    endtask

    task automatic model_resolve(input row_t r, output logic mis,
                                 output cpu_types_pkg::addr_t actual,
                                 output cpu_types_pkg::rob_idx_t rob);
        branch_pkg::bs_entry_t e;
        e = ref_ckpt[slot_of(r.tag)];
        if (r.taken || e.kind == branch_pkg::kind_jump) begin
            actual = r.target;
        end else begin
            actual = e.branch_pc + 4;
        end
        mis = (actual != e.predicted_pc);
        rob = e.rob_tail;
        if (mis) begin
            ref_map  = e.map_table;
            ref_free = e.free_list;
            // Younger branches on the wrong path are dropped
            for (int i = 0; i < branch_pkg::b_mask_width; i++) begin
                if (ref_ckpt[i].valid && (ref_ckpt[i].b_mask & r.tag) != '0) begin
                    ref_ckpt[i].valid = 1'b0;
                    ref_busy[i]       = 1'b0;
                end
            end
        end
        ref_ckpt[slot_of(r.tag)].valid = 1'b0;
        ref_busy = ref_busy & ~r.tag;
        for (int i = 0; i < branch_pkg::b_mask_width; i++) begin
            ref_ckpt[i].b_mask = ref_ckpt[i].b_mask & ~r.tag;
        end
    endtask

    task automatic wait_ack(input logic level, output int waited);
        waited = 0;
        do begin
            @(negedge clock);
            waited++;
        end while (disp_ack !== level);
    endtask

    // Called at the falling edge where the ack is seen high
    task automatic finish_dispatch(input row_t r);
        cpu_types_pkg::phys_idx_t exp_preg;
        branch_pkg::b_mask_t      exp_tag;
        int                       waited;
        model_dispatch(r, exp_preg, exp_tag);
        check_preg(disp_preg, exp_preg, "disp_preg");
        check_tag(disp_tag, exp_tag, "disp_tag");
        disp_req = 1'b0;
        wait_ack(1'b0, waited);
        check_flag(waited == 1, 1'b1, "disp_ack falling one cycle after disp_req");
    endtask

    task automatic serve_pending();
        if (have_pending) begin
            have_pending = 1'b0;
            check_flag(disp_ack, 1'b1, "disp_ack of the held dispatch");
            finish_dispatch(pending);
        end
    endtask

    task automatic run_dispatch(input row_t r);
        int waited;
        disp_req          = 1'b1;
        disp_kind         = r.kind;
        disp_dest         = r.dest;
        disp_pc           = r.pc;
        disp_predicted_pc = r.pred;
        disp_rob_tail     = r.rob;
        if (r.held) begin
            repeat (3) begin
                @(negedge clock);
                check_flag(disp_ack, 1'b0, "disp_ack with no free resource");
            end
            pending      = r;
            have_pending = 1'b1;
        end else begin
            wait_ack(1'b1, waited);
            check_flag(waited == 1, 1'b1, "disp_ack rising one cycle after disp_req");
            finish_dispatch(r);
        end
    endtask

    task automatic run_resolve(input row_t r);
        logic                    mis;
        cpu_types_pkg::addr_t    actual;
        cpu_types_pkg::rob_idx_t rob;
        resolve_valid  = 1'b1;
        resolve_tag    = r.tag;
        resolve_taken  = r.taken;
        resolve_target = r.target;
        model_resolve(r, mis, actual, rob);
        if (mis !== r.exp_mis) begin
            $display("The reference model and the stimulus table disagree on row tag %b", r.tag);
            fail_run();
        end
        // Recovery outputs are combinational and sampled mid cycle
        #5;
        check_flag(resolve_mispredict, mis, "resolve_mispredict");
        check_flag(restore_valid, mis, "restore_valid");
        if (mis) begin
            check_pc(restore_pc, actual, "restore_pc");
            check_rob(restore_rob_tail, rob, "restore_rob_tail");
        end
        @(negedge clock);
        resolve_valid = 1'b0;
        serve_pending();
    endtask

    task automatic run_retire();
        cpu_types_pkg::phys_idx_t preg;
        // Pick one of the registers that reset left busy
        preg = cpu_types_pkg::phys_idx_t'($urandom % 31 + 1);
        retire_valid = 1'b1;
        retire_preg  = preg;
        ref_free[preg] = 1'b1;
        for (int i = 0; i < branch_pkg::b_mask_width; i++) begin
            if (ref_ckpt[i].valid) begin
                ref_ckpt[i].free_list[preg] = 1'b1;
            end
        end
        @(negedge clock);
        retire_valid = 1'b0;
        serve_pending();
    endtask

    initial begin
        row_t r;
        void'($urandom(32'hb01d));
        reset             = 1'b1;
        disp_req          = 1'b0;
        disp_kind         = branch_pkg::kind_none;
        disp_dest         = '0;
        disp_pc           = '0;
        disp_predicted_pc = '0;
        disp_rob_tail     = '0;
        resolve_valid     = 1'b0;
        resolve_tag       = '0;
        resolve_taken     = 1'b0;
        resolve_target    = '0;
        retire_valid      = 1'b0;
        retire_preg       = '0;
        have_pending      = 1'b0;
        pending           = '0;
        build_ops();
        cycle_limit = 8 * ops.size() + 50;
        model_reset();
        repeat (4) @(negedge clock);
        reset = 1'b0;
        check_flag(disp_ack, 1'b0, "disp_ack after reset");
        check_flag(restore_valid, 1'b0, "restore_valid after reset");
        check_flag(resolve_mispredict, 1'b0, "resolve_mispredict after reset");
        foreach (ops[i]) begin
            r = ops[i];
            case (r.op)
                op_disp:    run_dispatch(r);
                op_resolve: run_resolve(r);
                default:    run_retire();
            endcase
        end
        if (have_pending) begin
            $display("A held dispatch was never acknowledged");
            fail_run();
        end else begin
            $display(">>> PASS");
            $finish;
        end
    end

endmodule

//--- flist.f
verilog/cpu_types_pkg.sv
verilog/branch_pkg.sv
verilog/branch_ifs.sv
verilog/branch_mask_alloc.sv
verilog/rename_state.sv
verilog/branch_stack.sv
verilog/branch_recovery_unit.sv
dv/branch_recovery_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the branch recovery testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
SIM=branch_recovery_sim

verilator --binary --timing --timescale 1ns/1ps -f flist.f \
    --top-module branch_recovery_tb --Mdir obj_dir -o "$SIM"
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/"$SIM" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -F -q ">>> FAIL" "$LOG"; then
    echo "Simulation reported failure"
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "Simulator exited with status $sim_status"
    exit 1
fi

echo "Simulation finished without failure"
exit 0
